// ==== source/mio_pkg.sv ====
`default_nettype none

package mio_pkg;

   // ############################
   // widths
   // ############################

   localparam int AW = 32;               // address and data width
   localparam int PW = 2*AW + 40;        // emesh packet width, 104

   // packet field lsb positions
   localparam int PKT_WRITE    = 0;                  // 1 bit
   localparam int PKT_DATAMODE = 1;                  // 2 bits
   localparam int PKT_CTRLMODE = 3;                  // 5 bits
   localparam int PKT_DSTADDR  = 8;                  // AW bits
   localparam int PKT_DATA     = PKT_DSTADDR + AW;   // AW bits
   localparam int PKT_SRCADDR  = PKT_DATA + AW;      // AW bits

   // ############################
   // types
   // ############################

   typedef logic [PW-1:0] packet_t;
   typedef logic [AW-1:0] addr_t;
   typedef logic [31:0]   word_t;
   typedef logic [7:0]    byte_t;
   typedef logic [15:0]   status_t;  // [15:8] sticky, [7:0] immediate

   // ############################
   // register map
   // ############################

   // word index, taken from dstaddr[5:2]
   localparam logic [3:0] REG_CONFIG   = 4'd0;  // 16 bit
   localparam logic [3:0] REG_STATUS   = 4'd1;  // 16 bit
   localparam logic [3:0] REG_CLKDIV   = 4'd2;  // 8 bit
   localparam logic [3:0] REG_CLKPHASE = 4'd3;  // 32 bit
   localparam logic [3:0] REG_ADDR0    = 4'd4;  // 32 bit

   // config bit fields
   localparam int CFG_TX_DIS    = 0;   // tx disable
   localparam int CFG_RX_DIS    = 1;   // rx disable
   localparam int CFG_MODE      = 2;   // 2 bit mode field
   localparam int CFG_DSIZE     = 4;   // 8 bit bytes per packet
   localparam int CFG_MSB_FIRST = 12;
   localparam int CFG_DDR       = 13;

   // mode encodings
   localparam logic [1:0] MODE_E = 2'b00;  // emesh packets
   localparam logic [1:0] MODE_D = 2'b01;  // data streaming
   localparam logic [1:0] MODE_A = 2'b10;  // auto address

   // ############################
   // receiver
   // ############################

   localparam int RX_FIFO_DEPTH = 4;
   localparam int RX_PTR_W      = $clog2(RX_FIFO_DEPTH);
   localparam int RX_PROG_LEVEL = 3;     // prog full at this count or more
   localparam int RX_WORD_BYTES = 4;     // max bytes packed per word

   localparam logic [1:0] DATAMODE_WORD = 2'b10;  // stamped on rx packets

endpackage

`default_nettype wire

// ==== source/mio_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module mio_regs import mio_pkg::*; (
   input  wire           clk,
   input  wire           nreset,
   // packet in
   input  wire           access_in,
   input  wire packet_t  packet_in,
   output logic          wait_out,
   // read response out
   output logic          resp_access,
   output packet_t       resp_packet,
   input  wire           resp_wait,
   // fifo flags
   input  wire           tx_full,
   input  wire           tx_prog_full,
   input  wire           tx_empty,
   input  wire           rx_full,
   input  wire           rx_prog_full,
   input  wire           rx_empty,
   // decoded config
   output logic          tx_en,
   output logic          rx_en,
   output logic          ddr_mode,
   output logic          emode,
   output logic          dmode,
   output logic          amode,
   output byte_t         datasize,
   output logic          lsbfirst,
   output addr_t         dstaddr,
   output byte_t         clkdiv,
   output logic [15:0]   clkphase0,
   output logic [15:0]   clkphase1
);

   // request fields
   logic       write_in;
   logic [1:0] datamode_in;
   logic [4:0] ctrlmode_in;
   addr_t      dstaddr_in;
   addr_t      srcaddr_in;
   word_t      data_in;
   logic [3:0] reg_idx;

   logic       reg_write;
   logic       reg_read;

   // register state
   logic [15:0] config_reg;
   status_t     status_reg;
   byte_t       status_in;
   byte_t       clkdiv_reg;
   word_t       clkphase_reg;
   addr_t       addr0_reg;
   logic [1:0]  cfg_mode;

   word_t       rd_data;
   packet_t     resp_next;

   // ############################
   // decode
   // ############################

   assign write_in    = packet_in[PKT_WRITE];
   assign datamode_in = packet_in[PKT_DATAMODE +: 2];
   assign ctrlmode_in = packet_in[PKT_CTRLMODE +: 5];
   assign dstaddr_in  = packet_in[PKT_DSTADDR +: AW];
   assign data_in     = packet_in[PKT_DATA +: AW];
   assign srcaddr_in  = packet_in[PKT_SRCADDR +: AW];
   assign reg_idx     = dstaddr_in[5:2];          // word index

   // stall only reads while the held response is not draining
   assign wait_out  = resp_access & resp_wait & ~write_in;
   assign reg_write = access_in & ~wait_out & write_in;
   assign reg_read  = access_in & ~wait_out & ~write_in;

   // ############################
   // config
   // ############################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         config_reg <= '0;                         // tx/rx on, emode
      end else if (reg_write && reg_idx == REG_CONFIG) begin
         config_reg <= data_in[15:0];
      end
   end

   assign cfg_mode = config_reg[CFG_MODE +: 2];
   assign tx_en    = ~config_reg[CFG_TX_DIS];      // stored as disable
   assign rx_en    = ~config_reg[CFG_RX_DIS];
   assign emode    = (cfg_mode == MODE_E);
   assign dmode    = (cfg_mode == MODE_D);
   assign amode    = (cfg_mode == MODE_A);
   assign datasize = config_reg[CFG_DSIZE +: 8];   // bytes per packet
   assign lsbfirst = ~config_reg[CFG_MSB_FIRST];
   assign ddr_mode = config_reg[CFG_DDR];

   // ############################
   // status
   // ############################

   assign status_in = {2'b00, tx_full, tx_prog_full, tx_empty,
                       rx_full, rx_prog_full, rx_empty};

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         status_reg <= '0;
      end else if (reg_write && reg_idx == REG_STATUS) begin
         status_reg <= data_in[15:0];              // loads both halves
      end else begin
         status_reg <= {status_reg[15:8] | status_in,  // sticky
                        status_in};                    // immediate
      end
   end

   // ############################
   // clock and address
   // ############################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         clkdiv_reg   <= '0;
         clkphase_reg <= '0;
         addr0_reg    <= '0;
      end else if (reg_write) begin
         if (reg_idx == REG_CLKDIV)   clkdiv_reg   <= data_in[7:0];
         if (reg_idx == REG_CLKPHASE) clkphase_reg <= data_in;
         if (reg_idx == REG_ADDR0)    addr0_reg    <= data_in;
      end
   end

   assign clkdiv    = clkdiv_reg;
   assign clkphase0 = clkphase_reg[15:0];    // [7:0] rise, [15:8] fall
   assign clkphase1 = clkphase_reg[31:16];
   assign dstaddr   = addr0_reg;             // rx destination

   // ############################
   // read response
   // ############################

   always_comb begin
      case (reg_idx)
         REG_CONFIG:   rd_data = {16'b0, config_reg};
         REG_STATUS:   rd_data = {16'b0, status_reg};
         REG_CLKDIV:   rd_data = {24'b0, clkdiv_reg};
         REG_CLKPHASE: rd_data = clkphase_reg;
         REG_ADDR0:    rd_data = addr0_reg;
         default:      rd_data = '0;          // unmapped
      endcase
   end

   always_comb begin
      resp_next = '0;
      resp_next[PKT_WRITE]              = 1'b1;        // responses are writes
      resp_next[PKT_DATAMODE +: 2]      = datamode_in;
      resp_next[PKT_CTRLMODE +: 5]      = ctrlmode_in;
      resp_next[PKT_DSTADDR +: AW]      = srcaddr_in;  // back to requester
      resp_next[PKT_DATA +: AW]         = rd_data;
      resp_next[PKT_SRCADDR +: AW]      = dstaddr_in;
   end

   // one entry buffer
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         resp_access <= 1'b0;
      end else if (reg_read) begin
         resp_access <= 1'b1;
      end else if (!resp_wait) begin
         resp_access <= 1'b0;                      // taken by merger
      end
   end

   always_ff @(posedge clk) begin
      if (reg_read) begin
         resp_packet <= resp_next;
      end
   end

endmodule

`default_nettype wire

// ==== source/mio_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module mio_rx import mio_pkg::*; (
   input  wire           clk,
   input  wire           nreset,
   // byte side
   input  wire           io_valid,
   input  wire byte_t    io_data,
   output logic          io_ready,
   // config
   input  wire           rx_en,
   input  wire           dmode,
   input  wire           amode,
   input  wire byte_t    datasize,
   input  wire           lsbfirst,
   input  wire addr_t    dstaddr,
   // packet out
   output logic          rxp_access,
   output packet_t       rxp_packet,
   input  wire           rxp_wait,
   // fifo flags
   output logic          rx_full,
   output logic          rx_prog_full,
   output logic          rx_empty
);

   logic       mode_ok;
   logic [2:0] grp_size;     // effective bytes per word, 1..4
   logic [2:0] byte_cnt;
   word_t      acc;
   word_t      acc_next;
   logic       take;
   logic       last;
   logic       push;
   logic       pop;

   addr_t      addr_cnt;
   addr_t      pkt_addr;
   packet_t    pkt_in;

   packet_t             fifo_mem [RX_FIFO_DEPTH];
   logic [RX_PTR_W-1:0] wr_ptr;
   logic [RX_PTR_W-1:0] rd_ptr;
   logic [RX_PTR_W:0]   count;

   // ############################
   // byte packing
   // ############################

   assign mode_ok  = rx_en & (dmode | amode);
   assign io_ready = ~rx_full;
   assign take     = io_valid & io_ready & mode_ok;  // emode bytes are dropped

   always_comb begin
      if (datasize == 8'd0)
         grp_size = 3'd1;                            // 0 means 1
      else if (datasize > 8'(RX_WORD_BYTES))
         grp_size = 3'(RX_WORD_BYTES);               // clamp
      else
         grp_size = datasize[2:0];
   end

   assign last = ((byte_cnt + 3'd1) >= grp_size);

   // lsb first places by count, msb first shifts up from the bottom
   assign acc_next = lsbfirst ? (acc | (word_t'(io_data) << {byte_cnt, 3'b000}))
                              : {acc[23:0], io_data};

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         byte_cnt <= '0;
         acc      <= '0;
      end else if (!mode_ok) begin
         byte_cnt <= '0;                             // drop partial group
         acc      <= '0;
      end else if (take) begin
         if (last) begin
            byte_cnt <= '0;
            acc      <= '0;
         end else begin
            byte_cnt <= byte_cnt + 3'd1;
            acc      <= acc_next;
         end
      end
   end

   assign push = take & last;                      // word done this edge

   // ############################
   // address
   // ############################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         addr_cnt <= '0;
      end else if (!rx_en || !amode) begin
         addr_cnt <= dstaddr;                        // reload
      end else if (push) begin
         addr_cnt <= addr_cnt + addr_t'(4);
      end
   end

   assign pkt_addr = amode ? addr_cnt : dstaddr;

   always_comb begin
      pkt_in = '0;
      pkt_in[PKT_WRITE]         = 1'b1;
      pkt_in[PKT_DATAMODE +: 2] = DATAMODE_WORD;
      pkt_in[PKT_DSTADDR +: AW] = pkt_addr;
      pkt_in[PKT_DATA +: AW]    = acc_next;        // zero extended word
   end

   // ############################
   // packet fifo
   // ############################

   assign pop = rxp_access & ~rxp_wait;

   always_ff @(posedge clk) begin
      if (push) begin
         fifo_mem[wr_ptr] <= pkt_in;
      end
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;        // wraps, depth is 2^n
         if (pop)  rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign rx_empty     = (count == '0);
   assign rx_full      = (count == (RX_PTR_W+1)'(RX_FIFO_DEPTH));
   assign rx_prog_full = (count >= (RX_PTR_W+1)'(RX_PROG_LEVEL));

   assign rxp_access = ~rx_empty;
   assign rxp_packet = fifo_mem[rd_ptr];           // head of queue

endmodule

`default_nettype wire

// ==== source/mio_out_arb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mio_out_arb import mio_pkg::*; (
   input  wire           clk,
   input  wire           nreset,
   // register responses, high priority
   input  wire           resp_access,
   input  wire packet_t  resp_packet,
   output logic          resp_wait,
   // received packets
   input  wire           rxp_access,
   input  wire packet_t  rxp_packet,
   output logic          rxp_wait,
   // merged output
   output logic          access_out,
   output packet_t       packet_out,
   input  wire           wait_in
);

   logic load_en;     // output register free this cycle
   logic grant_resp;
   logic grant_rxp;

   // ############################
   // grant
   // ############################

   assign load_en    = ~access_out | ~wait_in;    // empty or being taken
   assign grant_resp = load_en & resp_access;
   assign grant_rxp  = load_en & rxp_access & ~resp_access;

   assign resp_wait = ~load_en;                   // only stall blocks it
   assign rxp_wait  = ~load_en | resp_access;     // loses to responses

   // ############################
   // output register
   // ############################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         access_out <= 1'b0;
      end else if (load_en) begin
         access_out <= resp_access | rxp_access;
      end
   end

   // payload holds while wait_in stalls
   always_ff @(posedge clk) begin
      if (grant_resp) begin
         packet_out <= resp_packet;
      end else if (grant_rxp) begin
         packet_out <= rxp_packet;
      end
   end

endmodule

`default_nettype wire

// ==== source/mio_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mio_top import mio_pkg::*; (
   input  wire           clk,
   input  wire           nreset,
   // emesh packet in
   input  wire           access_in,
   input  wire packet_t  packet_in,
   output wire           wait_out,
   // emesh packet out
   output wire           access_out,
   output wire packet_t  packet_out,
   input  wire           wait_in,
   // pad side bytes
   input  wire           io_valid,
   input  wire byte_t    io_data,
   output wire           io_ready,
   // tx fifo status from outside
   input  wire           tx_full,
   input  wire           tx_prog_full,
   input  wire           tx_empty,
   // config out
   output wire           tx_en,
   output wire           rx_en,
   output wire           ddr_mode,
   output wire           emode,
   output wire           dmode,
   output wire           amode,
   output wire byte_t    datasize,
   output wire           lsbfirst,
   output wire addr_t    dstaddr,
   output wire byte_t    clkdiv,
   output wire [15:0]    clkphase0,
   output wire [15:0]    clkphase1
);

   // regs to merger
   wire          resp_access;
   packet_t      resp_packet;
   wire          resp_wait;

   // receiver to merger
   wire          rxp_access;
   packet_t      rxp_packet;
   wire          rxp_wait;

   // rx fifo flags into status
   wire          rx_full;
   wire          rx_prog_full;
   wire          rx_empty;

   // ############################
   // register block
   // ############################

   mio_regs u_regs (
      .clk(clk), .nreset(nreset),
      .access_in(access_in), .packet_in(packet_in), .wait_out(wait_out),
      .resp_access(resp_access), .resp_packet(resp_packet), .resp_wait(resp_wait),
      .tx_full(tx_full), .tx_prog_full(tx_prog_full), .tx_empty(tx_empty),
      .rx_full(rx_full), .rx_prog_full(rx_prog_full), .rx_empty(rx_empty),
      .tx_en(tx_en), .rx_en(rx_en), .ddr_mode(ddr_mode),
      .emode(emode), .dmode(dmode), .amode(amode),
      .datasize(datasize), .lsbfirst(lsbfirst), .dstaddr(dstaddr),
      .clkdiv(clkdiv), .clkphase0(clkphase0), .clkphase1(clkphase1)
   );

   // ############################
   // receiver
   // ############################

   mio_rx u_rx (
      .clk(clk), .nreset(nreset),
      .io_valid(io_valid), .io_data(io_data), .io_ready(io_ready),
      .rx_en(rx_en), .dmode(dmode), .amode(amode),
      .datasize(datasize), .lsbfirst(lsbfirst), .dstaddr(dstaddr),
      .rxp_access(rxp_access), .rxp_packet(rxp_packet), .rxp_wait(rxp_wait),
      .rx_full(rx_full), .rx_prog_full(rx_prog_full), .rx_empty(rx_empty)
   );

   // responses ahead of rx data
   mio_out_arb u_arb (
      .clk(clk), .nreset(nreset),
      .resp_access(resp_access), .resp_packet(resp_packet), .resp_wait(resp_wait),
      .rxp_access(rxp_access), .rxp_packet(rxp_packet), .rxp_wait(rxp_wait),
      .access_out(access_out), .packet_out(packet_out), .wait_in(wait_in)
   );

endmodule

`default_nettype wire

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
   output logic clk,
   output logic nreset
);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;                    // 20 ns period
   end

   initial begin
      nreset = 1'b0;
      repeat (5) @(posedge clk);                 // hold reset 5 cycles
      nreset <= 1'b1;
   end

endmodule

`default_nettype wire

// ==== sim/mio_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mio_tb import mio_pkg::*; ();

   localparam int TIMEOUT = 200;                 // cycles per wait loop

   wire          clk;
   wire          nreset;
   logic         access_in;
   packet_t      packet_in;
   wire          wait_out;
   wire          access_out;
   wire packet_t packet_out;
   logic         wait_in;
   logic         io_valid;
   byte_t        io_data;
   wire          io_ready;
   logic         tx_full;
   logic         tx_prog_full;
   logic         tx_empty;
   wire          tx_en;
   wire          rx_en;
   wire          ddr_mode;
   wire          emode;
   wire          dmode;
   wire          amode;
   wire byte_t   datasize;
   wire          lsbfirst;
   wire addr_t   dstaddr;
   wire byte_t   clkdiv;
   wire [15:0]   clkphase0;
   wire [15:0]   clkphase1;

   int          errors;
   int          checks;
   logic        timed_out;
   logic        wait_rand;                       // random wait_in on/off
   logic [31:0] data_lfsr = 32'h3349;
   logic [31:0] wait_lfsr = 32'h3349;
   packet_t     out_q[$];                        // packets taken off packet_out
   addr_t       addr0;                           // last ADDR0 written

   tb_clock u_clock (.clk(clk), .nreset(nreset));

   mio_top uut (.*);

   // ##############################
   // random source
   // ##############################

   // galois, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      int          i;
      r = '0;
      for (i = 0; i < n; i++) begin
         data_lfsr = lfsr_next(data_lfsr);       // one step per bit
         r = {r[30:0], data_lfsr[0]};
      end
      return r;
   endfunction

   always @(posedge clk) begin
      if (wait_rand) begin
         wait_lfsr = lfsr_next(wait_lfsr);
         wait_in <= wait_lfsr[0];
      end
   end

   // sink side, every accepted output packet in order
   always @(negedge clk) begin
      if (nreset && access_out && !wait_in) begin
         out_q.push_back(packet_out);            // taken on the next rising edge
      end
   end

   // ##############################
   // helpers
   // ##############################

   task automatic check(input string name, input word_t expected, input word_t actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic fail_wait(input string what);
      errors++;
      timed_out = 1'b1;
      $display("Timeout: %s", what);
   endtask

   // emesh layout
   function automatic packet_t make_pkt(input logic wr, input logic [1:0] dm,
                                        input addr_t dst, input word_t data,
                                        input addr_t src);
      packet_t p;
      p = '0;
      p[PKT_WRITE]          = wr;
      p[PKT_DATAMODE +: 2]  = dm;
      p[PKT_DSTADDR +: AW]  = dst;
      p[PKT_DATA +: AW]     = data;
      p[PKT_SRCADDR +: AW]  = src;
      return p;
   endfunction

   function automatic addr_t reg_addr(input logic [3:0] idx);
      logic [31:0] r;
      r = rand_bits(26);
      return {r[25:0], idx, 2'b00};              // upper bits ignored by decode
   endfunction

   function automatic word_t cfg_word(input logic [1:0] mode, input int size,
                                      input logic msb, input logic rx_off);
      word_t c;
      c = '0;
      c[1]    = rx_off;
      c[3:2]  = mode;
      c[11:4] = size[7:0];                       // bytes per packet
      c[12]   = msb;
      return c;
   endfunction

   task automatic send_packet(input packet_t p);
      int   n;
      logic ok;
      n = 0;
      ok = 1'b0;
      @(posedge clk);
      access_in <= 1'b1;
      packet_in <= p;
      while (!ok && n < TIMEOUT) begin
         @(negedge clk);
         ok = !wait_out;                         // taken on the coming edge
         @(posedge clk);
         n++;
      end
      access_in <= 1'b0;
      if (!ok) fail_wait("packet input held off by wait_out");
   endtask

   task automatic write_reg(input logic [3:0] idx, input word_t data);
      send_packet(make_pkt(1'b1, 2'b10, reg_addr(idx), data, rand_bits(32)));
   endtask

   task automatic issue_read(input logic [3:0] idx, output addr_t src,
                             output logic [1:0] dm);
      logic [31:0] r;
      src = rand_bits(32);
      r = rand_bits(2);
      dm = r[1:0];
      send_packet(make_pkt(1'b0, dm, reg_addr(idx), rand_bits(32), src));
   endtask

   task automatic take_packet(output packet_t p);
      int n;
      n = 0;
      while (out_q.size() == 0 && n < TIMEOUT) begin
         @(posedge clk);
         n++;
      end
      if (out_q.size() == 0) begin
         fail_wait("no packet on access_out");
         p = 'x;
      end else begin
         p = out_q.pop_front();
      end
   endtask

   task automatic take_response(input string name, input addr_t src,
                                input logic [1:0] dm, input word_t expected);
      packet_t p;
      take_packet(p);
      check({name, " write"}, 1, p[PKT_WRITE]);
      check({name, " dstaddr"}, src, p[PKT_DSTADDR +: AW]);  // back to requester
      check({name, " datamode"}, dm, p[PKT_DATAMODE +: 2]);
      check({name, " data"}, expected, p[PKT_DATA +: AW]);
   endtask

   task automatic read_reg(input string name, input logic [3:0] idx, input word_t expected);
      addr_t      src;
      logic [1:0] dm;
      issue_read(idx, src, dm);
      take_response(name, src, dm, expected);
   endtask

   task automatic expect_packet(input string name, input addr_t addr, input word_t data);
      packet_t p;
      take_packet(p);
      check({name, " write"}, 1, p[PKT_WRITE]);
      check({name, " datamode"}, 2'b10, p[PKT_DATAMODE +: 2]);
      check({name, " dstaddr"}, addr, p[PKT_DSTADDR +: AW]);
      check({name, " data"}, data, p[PKT_DATA +: AW]);
   endtask

   task automatic send_bytes(input byte_t bytes[$]);
      int   n;
      logic ok;
      @(posedge clk);
      foreach (bytes[i]) begin
         io_valid <= 1'b1;
         io_data  <= bytes[i];
         n = 0;
         ok = 1'b0;
         while (!ok && n < TIMEOUT) begin
            @(negedge clk);
            ok = io_ready;                       // moves on the coming edge
            @(posedge clk);
            n++;
         end
         if (!ok) fail_wait("io_ready stuck low");
      end
      io_valid <= 1'b0;
   endtask

   // one random group, expected word from the packing rule
   task automatic send_group(input int size, input logic lsb, output word_t expected);
      int          eff;
      int          i;
      logic [31:0] r;
      byte_t       bytes[$];
      eff = (size == 0) ? 1 : (size > 4) ? 4 : size;  // 0 counts as 1, clamp at 4
      expected = '0;
      for (i = 0; i < eff; i++) begin
         r = rand_bits(8);
         bytes.push_back(r[7:0]);
         if (lsb)
            expected = expected | (word_t'(r[7:0]) << (8*i));
         else
            expected = expected | (word_t'(r[7:0]) << (8*(eff-1-i)));  // first is top
      end
      send_bytes(bytes);
   endtask

   task automatic stream_groups(input string name, input word_t cfg, input int size,
                                input logic lsb, input int count, input logic auto_addr);
      word_t exp_q[$];
      word_t w;
      addr_t a;
      write_reg(REG_CONFIG, cfg);
      repeat (count) begin
         send_group(size, lsb, w);
         exp_q.push_back(w);
      end
      a = addr0;
      foreach (exp_q[i]) begin
         expect_packet(name, a, exp_q[i]);
         if (auto_addr) a = a + 32'd4;           // next word address
      end
   endtask

   task automatic set_wait_random(input logic on);
      @(negedge clk);
      wait_rand = on;
   endtask

   task automatic wait_reset();
      int n;
      n = 0;
      while (nreset !== 1'b1 && n < TIMEOUT) begin
         @(posedge clk);
         n++;
      end
      if (nreset !== 1'b1) fail_wait("reset never released");
      @(posedge clk);
   endtask

   // ##############################
   // tests
   // ##############################

   task automatic test_reset();
      check("reset tx_en", 1, tx_en);
      check("reset rx_en", 1, rx_en);
      check("reset emode", 1, emode);
      check("reset clkdiv", 0, clkdiv);
      check("reset access_out", 0, access_out);
      check("reset wait_out", 0, wait_out);
      check("reset io_ready", 1, io_ready);
      read_reg("reset config", REG_CONFIG, 0);
      read_reg("reset clkdiv read", REG_CLKDIV, 0);
   endtask

   task automatic test_regs();
      logic [31:0] r;
      logic [15:0] cfg;
      repeat (4) begin
         r = rand_bits(16);
         cfg = r[15:0];
         write_reg(REG_CONFIG, r);
         @(negedge clk);                         // new value one cycle on
         check("cfg tx_en", !cfg[0], tx_en);
         check("cfg rx_en", !cfg[1], rx_en);
         check("cfg emode", cfg[3:2] == 2'b00, emode);
         check("cfg dmode", cfg[3:2] == 2'b01, dmode);
         check("cfg amode", cfg[3:2] == 2'b10, amode);
         check("cfg datasize", cfg[11:4], datasize);
         check("cfg lsbfirst", !cfg[12], lsbfirst);
         check("cfg ddr_mode", cfg[13], ddr_mode);
         read_reg("cfg readback", REG_CONFIG, {16'h0, cfg});
         r = rand_bits(32);
         write_reg(REG_CLKDIV, r);
         @(negedge clk);
         check("clkdiv out", r[7:0], clkdiv);
         read_reg("clkdiv readback", REG_CLKDIV, {24'h0, r[7:0]});
         r = rand_bits(32);
         write_reg(REG_CLKPHASE, r);
         @(negedge clk);
         check("clkphase0 out", r[15:0], clkphase0);
         check("clkphase1 out", r[31:16], clkphase1);
         read_reg("clkphase readback", REG_CLKPHASE, r);
         r = rand_bits(32);
         write_reg(REG_ADDR0, r);
         @(negedge clk);
         check("addr0 out", r, dstaddr);
         read_reg("addr0 readback", REG_ADDR0, r);
      end
      read_reg("unmapped read", 4'd9, 0);
      write_reg(REG_CONFIG, 0);                  // back to emode
   endtask

   // status bits 5:0 are tx_full tx_prog_full tx_empty rx_full rx_prog_full rx_empty
   task automatic test_status();
      @(posedge clk);
      tx_full      <= 1'b1;
      tx_prog_full <= 1'b0;
      tx_empty     <= 1'b1;
      repeat (3) @(posedge clk);
      read_reg("status level", REG_STATUS, 32'h0000_2929);
      @(posedge clk);
      tx_prog_full <= 1'b1;                      // one cycle pulse
      @(posedge clk);
      tx_full      <= 1'b0;
      tx_prog_full <= 1'b0;
      tx_empty     <= 1'b0;
      repeat (3) @(posedge clk);
      read_reg("status sticky", REG_STATUS, 32'h0000_3901);
      write_reg(REG_STATUS, 0);
      repeat (2) @(posedge clk);
      read_reg("status cleared", REG_STATUS, 32'h0000_0101);  // only rx_empty again
   endtask

   task automatic test_dmode();
      addr0 = rand_bits(32);
      write_reg(REG_ADDR0, addr0);
      stream_groups("dmode lsb3", cfg_word(2'b01, 3, 1'b0, 1'b0), 3, 1'b1, 3, 1'b0);
      stream_groups("dmode msb3", cfg_word(2'b01, 3, 1'b1, 1'b0), 3, 1'b0, 3, 1'b0);
      stream_groups("dmode size0", cfg_word(2'b01, 0, 1'b1, 1'b0), 0, 1'b0, 3, 1'b0);
      stream_groups("dmode size6", cfg_word(2'b01, 6, 1'b0, 1'b0), 6, 1'b1, 3, 1'b0);
   endtask

   task automatic test_amode();
      addr0 = rand_bits(32);
      write_reg(REG_ADDR0, addr0);               // loaded while still in dmode
      stream_groups("amode", cfg_word(2'b10, 4, 1'b0, 1'b0), 4, 1'b1, 3, 1'b1);
      write_reg(REG_CONFIG, cfg_word(2'b10, 4, 1'b0, 1'b1));  // rx off, counter reloads
      stream_groups("amode restart", cfg_word(2'b10, 4, 1'b0, 1'b0), 4, 1'b1, 2, 1'b1);
   endtask

   task automatic test_backpressure();
      word_t      exp_q[$];
      word_t      w;
      packet_t    held;
      addr_t      src;
      logic [1:0] dm;
      int         n;
      write_reg(REG_CONFIG, cfg_word(2'b01, 2, 1'b0, 1'b0));
      set_wait_random(1'b0);
      @(posedge clk);
      wait_in <= 1'b1;                           // sink stalls
      repeat (5) begin
         send_group(2, 1'b1, w);
         exp_q.push_back(w);
      end
      // output register plus a full fifo
      n = 0;
      @(negedge clk);
      while (io_ready && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (io_ready) fail_wait("io_ready never dropped");
      held = packet_out;
      @(posedge clk);
      io_valid <= 1'b1;                          // sixth group waits at the pad
      io_data  <= 8'h5a;
      repeat (6) begin
         @(negedge clk);
         check("bp io_ready", 0, io_ready);
         check("bp access_out", 1, access_out);
         check("bp dstaddr held", held[PKT_DSTADDR +: AW], packet_out[PKT_DSTADDR +: AW]);
         check("bp data held", held[PKT_DATA +: AW], packet_out[PKT_DATA +: AW]);
      end
      @(posedge clk);
      io_valid <= 1'b0;
      issue_read(REG_ADDR0, src, dm);            // queued behind the stall
      @(negedge clk);
      check("bp held after read", held[PKT_DATA +: AW], packet_out[PKT_DATA +: AW]);
      @(posedge clk);
      access_in <= 1'b1;                         // second read while one is held
      packet_in <= make_pkt(1'b0, 2'b00, reg_addr(REG_CONFIG), '0, rand_bits(32));
      @(negedge clk);
      check("bp read stalled", 1, wait_out);
      @(posedge clk);
      access_in <= 1'b0;                         // withdrawn, never taken
      @(posedge clk);
      wait_in <= 1'b0;
      expect_packet("bp first", addr0, exp_q.pop_front());
      take_response("bp read", src, dm, addr0);  // ahead of the fifo
      foreach (exp_q[i]) begin
         expect_packet("bp queued", addr0, exp_q[i]);
      end
      send_group(2, 1'b1, w);
      expect_packet("bp last", addr0, w);
      repeat (10) @(posedge clk);
      check("bp leftover packets", 0, out_q.size());
   endtask

   // ##############################
   // main
   // ##############################

   initial begin
      access_in    = 1'b0;
      packet_in    = '0;
      wait_in      = 1'b0;
      io_valid     = 1'b0;
      io_data      = '0;
      tx_full      = 1'b0;
      tx_prog_full = 1'b0;
      tx_empty     = 1'b0;
      errors       = 0;
      checks       = 0;
      timed_out    = 1'b0;
      wait_rand    = 1'b0;
      addr0        = '0;

      wait_reset();
      if (!timed_out) test_reset();
      set_wait_random(1'b1);                     // sink stalls at random from here
      if (!timed_out) test_regs();
      if (!timed_out) test_status();
      if (!timed_out) test_dmode();
      if (!timed_out) test_amode();
      if (!timed_out) test_backpressure();

      $display("errors: %0d of %0d checks", errors, checks);
      if (errors == 0 && !timed_out) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== src.f ====
source/mio_pkg.sv
source/mio_regs.sv
source/mio_rx.sv
source/mio_out_arb.sv
source/mio_top.sv
sim/tb_clock.sv
sim/mio_tb.sv

// ==== Makefile ====
# Verilator build and run for the mio testbench

VERILATOR ?= verilator
TOP       ?= mio_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
PASS_MSG  ?= TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
